// File: verilog/tpu_consts.svh
/* Sizing macros for the lane cluster. Include this wherever a width, a lane
   count or a register depth is needed */
`ifndef TPU_CONSTS_SVH
`define TPU_CONSTS_SVH

//////////////////////////////////////////////////////////////////////
// Cluster geometry
//////////////////////////////////////////////////////////////////////

// Sixteen lanes, tied to the 4-bit rotation offset
`define LANE_COUNT	16

// Lane index and rotation offset width
`define LANE_IDX_W	4

//////////////////////////////////////////////////////////////////////
// Lane datapath
//////////////////////////////////////////////////////////////////////

// Lane word
`define DATA_WIDTH	32

// Registers per lane and their index width
`define REG_DEPTH	8
`define REG_IDX_W	3

`endif

// File: verilog/pkg_tpu.sv
/* Types shared by the lane cluster RTL: lane words, lane buses, opcodes,
   path selects and the broadcast instruction */
`include "tpu_consts.svh"

package pkg_tpu;

	//////////////////////////////////////////////////////////////////////
	// Data and buses
	//////////////////////////////////////////////////////////////////////

	typedef logic [`DATA_WIDTH-1:0]	data_t;			// One lane word
	typedef data_t [`LANE_COUNT-1:0]	lane_t;			// One word per lane
	typedef logic [`REG_IDX_W-1:0]	reg_idx_t;		// Register index

	//////////////////////////////////////////////////////////////////////
	// Instruction
	//////////////////////////////////////////////////////////////////////

	typedef enum logic [1:0] {
		OP_ADD	= 2'd0,
		OP_SUB	= 2'd1,
		OP_MAD	= 2'd2,								// Low word of a*b+c
		OP_AND	= 2'd3								// Also used to load scalars
	} op_e;

	// Bit 4 picks the lane path, low bits are offset or local choice
	typedef struct packed {
		logic						lane;			// Rotated lane bus
		logic [`LANE_IDX_W-1:0]		ofs;			// Offset, [1:0] local source
	} path_t;

	typedef struct packed {
		op_e						op;
		reg_idx_t					src1;
		reg_idx_t					src2;
		reg_idx_t					src3;
		reg_idx_t					dst;
		path_t						sel_path;		// Operand path
		path_t						sel_path_wb;	// Write-back path
		data_t						scalar;			// Broadcast scalar
		logic [`LANE_COUNT-1:0]		lane_mask;		// Write-back enable per lane
	} issue_t;

endpackage

// File: verilog/issue_stage.sv
/* Issue latch in front of the lanes. Each strobe is held and broadcast to
   every lane together with a one-cycle request */
`timescale 1ns/1ns

module issue_stage (
	input	logic				clock,
	input	logic				rst_n,
	input	logic				issue_valid,	// One-cycle strobe
	input	pkg_tpu::issue_t	instr,			// Instruction to broadcast
	output	logic				req,			// One cycle per instruction
	output	pkg_tpu::issue_t	cur				// Held for the lanes
);

	//////////////////////////////////////////////////////////////////////
	// Request flag
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			req <= 1'b0;
		end else begin
			req <= issue_valid;						// Lanes work the cycle after the strobe
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Instruction register
	//////////////////////////////////////////////////////////////////////

	// Held between strobes so the lanes see a stable instruction
	always_ff @(posedge clock) begin
		if (issue_valid) begin
			cur <= instr;
		end
	end

	// A strobed instruction carries no unknown bits into the lanes
	a_instr_known: assert property (@(posedge clock) disable iff (!rst_n)
		issue_valid |-> !$isunknown(instr))
		else $error("issue_stage: strobe with unknown instruction bits");

endmodule

// File: verilog/path_sel.sv
/* Operand and write-back path selector of one lane. Picks local sources or a
   rotated neighbour from the lane buses and drives this lane's reads out */
`timescale 1ns/1ns
`include "tpu_consts.svh"

module path_sel #(
	parameter int LANE_ID = 0
)(
	input	logic				req,			// Gates the lane-bus drive
	input	pkg_tpu::path_t		sel_path,		// Operand path
	input	pkg_tpu::path_t		sel_path_wb,	// Write-back path
	input	pkg_tpu::data_t		scalar,			// Broadcast scalar
	input	pkg_tpu::lane_t		lane_src1,		// Reads of all lanes
	input	pkg_tpu::lane_t		lane_src2,
	input	pkg_tpu::lane_t		lane_src3,
	input	pkg_tpu::lane_t		lane_wb,		// ALU results of all lanes
	input	pkg_tpu::data_t		src_data1,		// This lane's reads
	input	pkg_tpu::data_t		src_data2,
	input	pkg_tpu::data_t		src_data3,
	input	pkg_tpu::data_t		wb_in,			// This lane's ALU result
	output	pkg_tpu::data_t		op_data1,		// To ALU
	output	pkg_tpu::data_t		op_data2,
	output	pkg_tpu::data_t		op_data3,
	output	pkg_tpu::data_t		wb_data,		// To register file
	output	pkg_tpu::data_t		bus_src1,		// Onto the lane buses
	output	pkg_tpu::data_t		bus_src2,
	output	pkg_tpu::data_t		bus_src3
);
	import pkg_tpu::*;

	localparam logic [`LANE_IDX_W-1:0] LANE_OFS = LANE_ID[`LANE_IDX_W-1:0];

	logic [`LANE_IDX_W-1:0]		op_lane;
	logic [`LANE_IDX_W-1:0]		wb_lane;
	data_t						local_src;
	data_t						local_wb;

	assign op_lane = sel_path.ofs + LANE_OFS;		// Wraps modulo lane count
	assign wb_lane = sel_path_wb.ofs + LANE_OFS;

	//////////////////////////////////////////////////////////////////////
	// Local choices
	//////////////////////////////////////////////////////////////////////

	// One local source feeds all three operands
	always_comb begin
		case (sel_path.ofs[1:0])
			2'd1:		local_src = src_data1;
			2'd2:		local_src = src_data2;
			2'd3:		local_src = src_data3;
			default:	local_src = scalar;
		endcase
	end

	always_comb begin
		case (sel_path_wb.ofs[1:0])
			2'd1:		local_wb = src_data1;
			2'd2:		local_wb = src_data2;
			2'd3:		local_wb = src_data3;
			default:	local_wb = wb_in;		// Own ALU result
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Lane path or local path
	//////////////////////////////////////////////////////////////////////

	assign op_data1 = sel_path.lane ? lane_src1[op_lane] : local_src;
	assign op_data2 = sel_path.lane ? lane_src2[op_lane] : local_src;
	assign op_data3 = sel_path.lane ? lane_src3[op_lane] : local_src;
	assign wb_data  = sel_path_wb.lane ? lane_wb[wb_lane] : local_wb;

	// Idle lanes put zero on the buses
	assign bus_src1 = req ? src_data1 : '0;
	assign bus_src2 = req ? src_data2 : '0;
	assign bus_src3 = req ? src_data3 : '0;

endmodule

// File: verilog/vector_lane.sv
/* One SIMD lane with register file, path selection, ALU and exec register.
   Reads after the issue edge, executes one edge later, writes back the next */
`timescale 1ns/1ns
`include "tpu_consts.svh"

module vector_lane #(
	parameter int LANE_ID = 0
)(
	input	logic				clock,
	input	logic				rst_n,
	input	logic				req,			// Instruction in operand stage
	input	pkg_tpu::issue_t	cur,			// Broadcast instruction
	input	pkg_tpu::lane_t		src1_bus,		// Reads of all lanes
	input	pkg_tpu::lane_t		src2_bus,
	input	pkg_tpu::lane_t		src3_bus,
	input	pkg_tpu::lane_t		wb_bus,			// Exec results of all lanes
	output	pkg_tpu::data_t		bus_src1,
	output	pkg_tpu::data_t		bus_src2,
	output	pkg_tpu::data_t		bus_src3,
	output	pkg_tpu::data_t		bus_wb,
	output	logic				wb_en,			// Write-back stage active
	output	pkg_tpu::data_t		wb_word			// Zero when masked off
);
	import pkg_tpu::*;

	typedef struct packed {
		data_t		result;
		data_t		src1;
		data_t		src2;
		data_t		src3;
		reg_idx_t	dst;
		path_t		sel_path_wb;
		logic		mask;
	} exec_t;

	data_t		rf [`REG_DEPTH];
	data_t		rd1;
	data_t		rd2;
	data_t		rd3;
	data_t		op1;
	data_t		op2;
	data_t		op3;
	data_t		alu_out;
	data_t		wb_sel;
	exec_t		ex_q;
	logic		ex_valid;
	logic		rf_we;

	//////////////////////////////////////////////////////////////////////
	// Operand stage
	//////////////////////////////////////////////////////////////////////

	assign rd1 = rf[cur.src1];						// No bypass between stages
	assign rd2 = rf[cur.src2];
	assign rd3 = rf[cur.src3];

	path_sel #(.LANE_ID(LANE_ID)) u_path_op (
		.req		(req),
		.sel_path	(cur.sel_path),
		.sel_path_wb('0),							// Write-back side unused here
		.scalar		(cur.scalar),
		.lane_src1	(src1_bus),
		.lane_src2	(src2_bus),
		.lane_src3	(src3_bus),
		.lane_wb	('0),
		.src_data1	(rd1),
		.src_data2	(rd2),
		.src_data3	(rd3),
		.wb_in		('0),
		.op_data1	(op1),
		.op_data2	(op2),
		.op_data3	(op3),
		.wb_data	(),
		.bus_src1	(bus_src1),
		.bus_src2	(bus_src2),
		.bus_src3	(bus_src3)
	);

	always_comb begin
		case (cur.op)
			OP_ADD:		alu_out = op1 + op2;
			OP_SUB:		alu_out = op1 - op2;
			OP_MAD:		alu_out = op1 * op2 + op3;	// Low 32 bits
			default:	alu_out = op1 & op2;
		endcase
	end

	//////////////////////////////////////////////////////////////////////
	// Exec register
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			ex_valid <= 1'b0;
		end else begin
			ex_valid <= req;
		end
	end

	always_ff @(posedge clock) begin
		if (req) begin
			ex_q.result		 <= alu_out;
			ex_q.src1		 <= rd1;				// Reads kept for write-back paths
			ex_q.src2		 <= rd2;
			ex_q.src3		 <= rd3;
			ex_q.dst		 <= cur.dst;
			ex_q.sel_path_wb <= cur.sel_path_wb;
			ex_q.mask		 <= cur.lane_mask[LANE_ID];
		end
	end

	assign bus_wb = ex_q.result;

	//////////////////////////////////////////////////////////////////////
	// Write-back stage
	//////////////////////////////////////////////////////////////////////

	path_sel #(.LANE_ID(LANE_ID)) u_path_wb (
		.req		(1'b0),						// Operand side unused here
		.sel_path	('0),
		.sel_path_wb(ex_q.sel_path_wb),
		.scalar		('0),
		.lane_src1	('0),
		.lane_src2	('0),
		.lane_src3	('0),
		.lane_wb	(wb_bus),
		.src_data1	(ex_q.src1),
		.src_data2	(ex_q.src2),
		.src_data3	(ex_q.src3),
		.wb_in		(ex_q.result),
		.op_data1	(),
		.op_data2	(),
		.op_data3	(),
		.wb_data	(wb_sel),
		.bus_src1	(),
		.bus_src2	(),
		.bus_src3	()
	);

	assign rf_we   = ex_valid & ex_q.mask;
	assign wb_en   = ex_valid;
	assign wb_word = rf_we ? wb_sel : '0;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `REG_DEPTH; i++) begin
				rf[i] <= '0;
			end
		end else if (rf_we) begin
			rf[ex_q.dst] <= wb_sel;
		end
	end

	// This lane's slot on the shared result bus carries its own result
	a_own_wb_slot: assert property (@(posedge clock) disable iff (!rst_n)
		ex_valid |-> wb_bus[LANE_ID] == bus_wb)
		else $error("vector_lane %0d: own slot on the result bus is wrong", LANE_ID);

endmodule

// File: verilog/result_collector.sv
/* Drain of the lane cluster. Registers the lane write-back words and their
   sum, and pulses result_valid once per instruction */
`timescale 1ns/1ns
`include "tpu_consts.svh"

module result_collector (
	input	logic					clock,
	input	logic					rst_n,
	input	logic [`LANE_COUNT-1:0]	wb_en,			// Lanes in write-back
	input	pkg_tpu::lane_t			wb_words,		// Masked lanes are zero
	output	logic					result_valid,	// One-cycle pulse
	output	pkg_tpu::lane_t			result,
	output	pkg_tpu::data_t			result_sum		// Wraps at 32 bits
);
	import pkg_tpu::*;

	data_t		sum_next;
	logic		wb_active;

	assign wb_active = |wb_en;

	// Reduction over all lanes
	always_comb begin
		sum_next = '0;
		for (int i = 0; i < `LANE_COUNT; i++) begin
			sum_next = sum_next + wb_words[i];
		end
	end

	//////////////////////////////////////////////////////////////////////
	// Output registers
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			result_valid <= 1'b0;
		end else begin
			result_valid <= wb_active;
		end
	end

	always_ff @(posedge clock) begin
		if (wb_active) begin
			result	   <= wb_words;					// Held until the next result
			result_sum <= sum_next;
		end
	end

	// All lanes run in lockstep, so they reach write-back together
	a_lanes_lockstep: assert property (@(posedge clock) disable iff (!rst_n)
		wb_active |-> (wb_en == '1))
		else $error("result_collector: lanes out of step");

endmodule

// File: verilog/lane_cluster.sv
/* Top of the SIMD lane cluster. Issue stage, sixteen generated lanes on the
   shared lane buses, and the result collector */
`timescale 1ns/1ns
`include "tpu_consts.svh"

module lane_cluster (
	input	logic				clock,
	input	logic				rst_n,
	input	logic				issue_valid,	// One-cycle strobe
	input	pkg_tpu::issue_t	instr,
	output	logic				result_valid,	// One-cycle pulse
	output	pkg_tpu::lane_t		result,
	output	pkg_tpu::data_t		result_sum
);
	import pkg_tpu::*;

	logic						req;
	issue_t						cur;
	lane_t						src1_bus;		// Gated register reads
	lane_t						src2_bus;
	lane_t						src3_bus;
	lane_t						wb_bus;			// Exec results
	lane_t						wb_words;
	logic [`LANE_COUNT-1:0]		wb_en;

	issue_stage u_issue (
		.clock		(clock),
		.rst_n		(rst_n),
		.issue_valid(issue_valid),
		.instr		(instr),
		.req		(req),
		.cur		(cur)
	);

	//////////////////////////////////////////////////////////////////////
	// Lanes
	//////////////////////////////////////////////////////////////////////

	for (genvar i = 0; i < `LANE_COUNT; i++) begin : g_lane
		vector_lane #(.LANE_ID(i)) u_lane (
			.clock		(clock),
			.rst_n		(rst_n),
			.req		(req),
			.cur		(cur),
			.src1_bus	(src1_bus),
			.src2_bus	(src2_bus),
			.src3_bus	(src3_bus),
			.wb_bus		(wb_bus),
			.bus_src1	(src1_bus[i]),
			.bus_src2	(src2_bus[i]),
			.bus_src3	(src3_bus[i]),
			.bus_wb		(wb_bus[i]),
			.wb_en		(wb_en[i]),
			.wb_word	(wb_words[i])
		);
	end

	result_collector u_collect (
		.clock		 (clock),
		.rst_n		 (rst_n),
		.wb_en		 (wb_en),
		.wb_words	 (wb_words),
		.result_valid(result_valid),
		.result		 (result),
		.result_sum	 (result_sum)
	);

endmodule

// File: verification/lane_cluster_tb.sv
/* Testbench for the lane cluster. Drives LFSR-built instructions into the DUT
   and checks every result against a register model of the sixteen lanes */
`timescale 1ns/1ns
`include "tpu_consts.svh"

module lane_cluster_tb;
	import pkg_tpu::*;

	localparam int CLK_PERIOD = 20;
	localparam int RESET_CYCLES = 8;
	localparam int GAP = 2;							// Idle cycles after a spaced strobe
	localparam int N_SPACED = 128;					// Strobes of the spaced tests
	localparam int N_B2B = 32;
	localparam int N_TESTS = 7;
	localparam int DRAIN_LIMIT = 10;
	localparam int WATCHDOG_CYCLES = RESET_CYCLES + N_SPACED * (GAP + 1) + N_B2B
		+ N_TESTS * (DRAIN_LIMIT + 2) + 100;

	logic			clock;
	logic			rst_n;
	logic			issue_valid;
	issue_t			instr;
	logic			result_valid;
	lane_t			result;
	data_t			result_sum;

	logic [31:0]	lfsr_state;
	data_t			rf_model [`LANE_COUNT][`REG_DEPTH];
	int				pend_due[$];					// Model writes waiting for their edge
	int				pend_lane[$];
	int				pend_reg[$];
	data_t			pend_val[$];
	lane_t			exp_result_q[$];
	data_t			exp_sum_q[$];
	lane_t			exp_result;
	data_t			exp_sum;
	int				edge_count;
	int				strobe_count;
	int				pulse_count;
	int				check_count;
	int				check_errors;					// Written by the checker only
	int				flow_errors;					// Written by the stimulus only
	string			cur_test;

	lane_cluster DUT (
		.clock		 (clock),
		.rst_n		 (rst_n),
		.issue_valid (issue_valid),
		.instr		 (instr),
		.result_valid(result_valid),
		.result		 (result),
		.result_sum	 (result_sum)
	);

	initial begin
		clock = 1'b0;
		forever #(CLK_PERIOD / 2) clock = ~clock;
	end

	always @(posedge clock) begin
		edge_count <= edge_count + 1;
	end

	//////////////////////////////////////////////////////////////////////
	// Random fields
	//////////////////////////////////////////////////////////////////////

	// Fibonacci LFSR, x^32 + x^22 + x^2 + x + 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic take_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_step(lfsr_state);			// One step per bit
			v = {v[30:0], lfsr_state[0]};
		end
	endtask

	task automatic random_instr(output issue_t ins);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] c;
		take_bits(32, a);
		take_bits(32, b);
		take_bits(8, c);
		ins = {a, b, c[7:0]};							// All 72 bits random
	endtask

	// Forces the fields a test is about, the rest stays random
	task automatic shape_instr(input int mode, input int i, inout issue_t ins);
		case (mode)
			0, 1: begin									// Scalar load, then read-back
				ins.op = OP_AND;
				ins.sel_path = (mode == 0) ? 5'b0_0000 : 5'b0_0001;
				ins.sel_path_wb = '0;
				ins.dst = i[2:0];
				ins.src1 = i[2:0];
				if (mode == 1 || i < 8) ins.lane_mask = '1;
			end
			2: begin
				ins.op = op_e'(i[1:0]);
				ins.sel_path = 5'b1_0000;				// Lane path, offset 0
				ins.sel_path_wb = '0;
				ins.lane_mask = '1;
			end
			3: begin
				ins.sel_path = {1'b1, 4'(i % 15 + 1)};	// Every nonzero offset
				ins.sel_path_wb = '0;
				ins.lane_mask = '1;
			end
			4: begin
				ins.sel_path_wb.lane = i[0];
				if (!i[0]) ins.sel_path_wb.ofs = 4'(i / 2 % 3 + 1);
				ins.lane_mask = '1;
			end
			5: if (i == 0) ins.lane_mask = '0;
			default: ;
		endcase
	endtask

	//////////////////////////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////////////////////////

	// Reads after the issue edge, writes land two edges later
	task automatic model_issue(input issue_t ins, input int issue_edge);
		data_t	rd [3][`LANE_COUNT];
		data_t	alu [`LANE_COUNT];
		data_t	opd [3];
		data_t	local_src;
		data_t	wb;
		lane_t	res;
		data_t	sum;
		int		k;
		while (pend_due.size() > 0 && pend_due[0] <= issue_edge) begin
			k = pend_lane.pop_front();
			rf_model[k][pend_reg.pop_front()] = pend_val.pop_front();
			void'(pend_due.pop_front());
		end
		for (int l = 0; l < `LANE_COUNT; l++) begin
			rd[0][l] = rf_model[l][ins.src1];
			rd[1][l] = rf_model[l][ins.src2];
			rd[2][l] = rf_model[l][ins.src3];
		end
		for (int l = 0; l < `LANE_COUNT; l++) begin
			k = (l + int'(ins.sel_path.ofs)) % `LANE_COUNT;
			local_src = (ins.sel_path.ofs[1:0] == 2'd0) ? ins.scalar
				: rd[int'(ins.sel_path.ofs[1:0]) - 1][l];
			for (int j = 0; j < 3; j++) begin
				opd[j] = ins.sel_path.lane ? rd[j][k] : local_src;
			end
			case (ins.op)
				OP_ADD:		alu[l] = opd[0] + opd[1];
				OP_SUB:		alu[l] = opd[0] - opd[1];
				OP_MAD:		alu[l] = opd[0] * opd[1] + opd[2];	// Low word only
				default:	alu[l] = opd[0] & opd[1];
			endcase
		end
		sum = '0;
		for (int l = 0; l < `LANE_COUNT; l++) begin
			k = (l + int'(ins.sel_path_wb.ofs)) % `LANE_COUNT;
			if (ins.sel_path_wb.lane) begin
				wb = alu[k];								// Neighbour's ALU result
			end else if (ins.sel_path_wb.ofs[1:0] == 2'd0) begin
				wb = alu[l];
			end else begin
				wb = rd[int'(ins.sel_path_wb.ofs[1:0]) - 1][l];
			end
			res[l] = ins.lane_mask[l] ? wb : '0;			// Masked lanes report zero
			sum = sum + res[l];
			if (ins.lane_mask[l]) begin
				pend_due.push_back(issue_edge + 2);
				pend_lane.push_back(l);
				pend_reg.push_back(int'(ins.dst));
				pend_val.push_back(wb);
			end
		end
		exp_result_q.push_back(res);
		exp_sum_q.push_back(sum);
	endtask

	//////////////////////////////////////////////////////////////////////
	// Stimulus and checks
	//////////////////////////////////////////////////////////////////////

	task automatic issue_instr(input issue_t ins, input int gap);
		@(negedge clock);
		model_issue(ins, edge_count + 1);				// Sampled at the next edge
		instr = ins;
		issue_valid = 1'b1;
		strobe_count++;
		repeat (gap) begin
			@(negedge clock);
			issue_valid = 1'b0;
		end
	endtask

	task automatic drain_results(input int pulse_base);
		int waited;
		waited = 0;
		@(negedge clock);
		issue_valid = 1'b0;
		while (exp_result_q.size() > 0 && waited < DRAIN_LIMIT) begin
			@(negedge clock);
			waited++;
		end
		if (exp_result_q.size() > 0) begin
			$display("%s: %0d results did not arrive", cur_test, exp_result_q.size());
			flow_errors++;
			exp_result_q.delete();
			exp_sum_q.delete();
		end
		if (pulse_count - pulse_base != strobe_count) begin
			$display("%s: %0d result pulses for %0d strobes", cur_test,
				pulse_count - pulse_base, strobe_count);
			flow_errors++;
		end
	endtask

	task automatic run_test(input string name, input int mode, input int count, input int gap);
		issue_t	ins;
		int		pulse_base;
		int		err_base;
		cur_test = name;
		strobe_count = 0;
		pulse_base = pulse_count;
		err_base = check_errors + flow_errors;
		for (int i = 0; i < count; i++) begin
			random_instr(ins);
			shape_instr(mode, i, ins);
			issue_instr(ins, gap);
		end
		drain_results(pulse_base);
		$display("%-10s %0d strobes, %0d errors", name, strobe_count,
			check_errors + flow_errors - err_base);
	endtask

	// Outputs are registered, so the falling edge sees them settled
	always @(negedge clock) begin
		if (rst_n && result_valid) begin
			pulse_count++;
			if (exp_result_q.size() == 0) begin
				$display("%s: result_valid with no instruction outstanding", cur_test);
				check_errors++;
			end else begin
				exp_result = exp_result_q.pop_front();
				exp_sum = exp_sum_q.pop_front();
				for (int l = 0; l < `LANE_COUNT; l++) begin
					check_count++;
					if (result[l] !== exp_result[l]) begin
						$display("[ERROR] %s lane %0d: expected %h, actual %h",
							cur_test, l, exp_result[l], result[l]);
						check_errors++;
					end
				end
				check_count++;
				if (result_sum !== exp_sum) begin
					$display("[ERROR] %s sum: expected %h, actual %h",
						cur_test, exp_sum, result_sum);
					check_errors++;
				end
			end
		end
	end

	initial begin
		rst_n = 1'b0;
		issue_valid = 1'b0;
		instr = '0;
		lfsr_state = 32'h4a59_3260;
		for (int l = 0; l < `LANE_COUNT; l++) begin
			for (int r = 0; r < `REG_DEPTH; r++) begin
				rf_model[l][r] = '0;
			end
		end
		repeat (RESET_CYCLES) @(negedge clock);
		rst_n = 1'b1;
		run_test("load", 0, 24, GAP);
		run_test("readback", 1, 8, GAP);
		run_test("arith", 2, 24, GAP);
		run_test("rotation", 3, 24, GAP);
		run_test("wb_paths", 4, 24, GAP);
		run_test("mask_sum", 5, 24, GAP);
		run_test("back2back", 6, N_B2B, 0);				// One strobe per cycle
		$display("%0d tests, %0d checks, %0d errors", N_TESTS, check_count,
			check_errors + flow_errors);
		if (check_errors + flow_errors == 0) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

	// Ends a stuck run
	initial begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("test failed");
		$finish;
	end

endmodule

// File: lane_cluster.f
+incdir+verilog
verilog/pkg_tpu.sv
verilog/issue_stage.sv
verilog/path_sel.sv
verilog/vector_lane.sv
verilog/result_collector.sv
verilog/lane_cluster.sv
verification/lane_cluster_tb.sv

// File: Makefile
# Verilator build and run of the lane cluster testbench

TOP = lane_cluster_tb
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench, check $(LOG)"
	@echo "make clean  remove obj_dir and $(LOG)"
	@echo "make help   list these targets"

test:
	verilator --binary --timing --assert --top-module $(TOP) -f lane_cluster.f \
		--Mdir obj_dir -o $(TOP)
	./obj_dir/$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
		if [ $$status -ne 0 ] || grep -q "test failed" $(LOG); then exit 1; fi

clean:
	rm -rf obj_dir $(LOG)
